// ==== vic_pkg.sv ====
package vic_pkg;

    // sprite and bus cycle geometry
    localparam int num_sprites     = 8;
    localparam int ticks_per_cycle = 32;
    localparam int dav_tick_low    = 14;
    localparam int dav_tick_high   = 30;

    // raster frame and badline window
    localparam int raster_lines  = 312;
    localparam int badline_first = 'h030;
    localparam int badline_last  = 'h0f7;

    // slot positions, cycles counted from 1 within a line
    localparam int sprite_lo_first     = 1;
    localparam int sprite_lo_last      = 10;
    localparam int refresh_first_cycle = 11;
    localparam int vc_load_cycle       = 14;
    localparam int c_first_cycle       = 15;
    localparam int c_last_cycle        = 54;
    localparam int g_last_cycle        = 55;
    localparam int dma_check_cycle     = 55;
    localparam int sprite_hi_first     = 58;
    localparam int sprite_hi_last      = 63;
    localparam int row_check_cycle     = 58;
    localparam int mc_update_cycle     = 15;

    // sprite data is 21 rows of 3 bytes
    localparam int sprite_rows  = 21;
    localparam int char_buf_len = 40;

    // address put out when a slot fetches nothing useful
    localparam logic [13:0] idle_addr = 14'h3fff;

    typedef enum logic [3:0] {
        vic_lp,
        vic_hs1, vic_ls2, vic_hs3,
        vic_lr,
        vic_lg,
        vic_hrc, vic_hgc,
        vic_hrx, vic_hgi,
        vic_li, vic_hi
    } cycle_t;

    typedef enum logic [1:0] {st_border, st_display, st_idle} seq_state_t;

endpackage

// ==== vic_fetch_if.sv ====
interface vic_fetch_if import vic_pkg::*; ();

    // slot type for the current phase
    cycle_t                 cycle_type;
    // one tick strobe when read data is valid
    logic                   phi_phase_start_dav;
    logic                   phase_high;
    logic [2:0]             sprite_cnt;
    logic [num_sprites-1:0] sprite_dma;
    logic                   idle;
    logic                   badline;
    // low while a badline c-access owns the bus
    logic                   aec;

    modport seq (
        output cycle_type, phi_phase_start_dav, phase_high, sprite_cnt,
        output sprite_dma, idle, badline, aec
    );

    modport fetch (
        input cycle_type, phi_phase_start_dav, sprite_cnt, sprite_dma, idle, aec
    );

    modport addr (
        input cycle_type, phi_phase_start_dav, phase_high, sprite_cnt,
        input sprite_dma, idle, badline
    );

endinterface

// ==== vic_cycle_seq.sv ====
module vic_cycle_seq import vic_pkg::*; #(
    parameter int cycles_per_line = 63
) (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  logic                     den,
    input  logic [2:0]               yscroll,
    input  logic [num_sprites-1:0]   sprite_en,
    input  logic [8*num_sprites-1:0] sprite_y,
    output logic [8:0]               raster,
    output logic [6:0]               cycle_num,
    vic_fetch_if.seq                 f
);

    logic [4:0]             tick;
    logic                   cycle_end;
    logic                   phase_high;
    logic                   dav;
    logic                   lo_dav;
    logic                   den_latched;
    logic                   in_window;
    logic                   badline;
    seq_state_t             state;
    logic [num_sprites-1:0] dma;
    logic [4:0]             sprite_row [num_sprites];
    logic                   spr_slot;
    logic [3:0]             spr_k;
    logic [2:0]             spr_num;
    cycle_t                 ctype;

    assign cycle_end  = (tick == 5'(ticks_per_cycle - 1));
    assign phase_high = tick[4];
    assign dav        = (tick == 5'(dav_tick_low)) || (tick == 5'(dav_tick_high));
    assign lo_dav     = dav && !phase_high;

    // tick, cycle and raster counters
    // cycle_num runs 1..cycles_per_line, 0 only right after reset
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            tick      <= '0;
            cycle_num <= '0;
            raster    <= '0;
        end else begin
            tick <= cycle_end ? 5'd0 : tick + 5'd1;
            if (cycle_end) begin
                if (cycle_num == 7'(cycles_per_line)) begin
                    cycle_num <= 7'd1;
                    if (raster == 9'(raster_lines - 1)) begin
                        raster <= '0;
                    end else begin
                        raster <= raster + 9'd1;
                    end
                end else begin
                    cycle_num <= cycle_num + 7'd1;
                end
            end
        end
    end

    // display enable is sampled during line 0x30 only
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            den_latched <= 1'b0;
        end else if (raster == 9'd0) begin
            den_latched <= 1'b0;
        end else if (raster == 9'(badline_first) && den) begin
            den_latched <= 1'b1;
        end
    end

    assign in_window = (raster >= 9'(badline_first)) && (raster <= 9'(badline_last));
    assign badline   = den_latched && in_window && (raster[2:0] == yscroll);

    // line state
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            state <= st_border;
        end else if (!in_window || !den_latched) begin
            state <= st_border;
        end else if (badline) begin
            state <= st_display;
        end else if (state == st_border) begin
            state <= st_idle;
        end
    end

    // two cycles per sprite, sprites 3..7 early in the line and 0..2 at its end
    always_comb begin
        spr_slot = 1'b0;
        spr_k    = '0;
        spr_num  = '0;
        if (cycle_num >= 7'(sprite_lo_first) && cycle_num <= 7'(sprite_lo_last)) begin
            spr_slot = 1'b1;
            spr_k    = 4'(cycle_num - 7'(sprite_lo_first));
            spr_num  = spr_k[3:1] + 3'd3;
        end else if (cycle_num >= 7'(sprite_hi_first) &&
                     cycle_num <= 7'(sprite_hi_last)) begin
            spr_slot = 1'b1;
            spr_k    = 4'(cycle_num - 7'(sprite_hi_first));
            spr_num  = spr_k[3:1];
        end
    end

    // slot table
    always_comb begin
        ctype = phase_high ? vic_hi : vic_li;
        if (spr_slot) begin
            if (!spr_k[0]) begin
                ctype = phase_high ? vic_hs1 : vic_lp;
            end else begin
                ctype = phase_high ? vic_hs3 : vic_ls2;
            end
        end else if (!phase_high) begin
            if (cycle_num >= 7'(refresh_first_cycle) && cycle_num <= 7'(c_first_cycle)) begin
                ctype = vic_lr;
            end else if (cycle_num > 7'(c_first_cycle) && cycle_num <= 7'(g_last_cycle)) begin
                ctype = vic_lg;
            end
        end else begin
            // first c-slot follows a refresh, the rest follow a g-access
            if (cycle_num == 7'(c_first_cycle)) begin
                ctype = badline ? vic_hrc : vic_hrx;
            end else if (cycle_num > 7'(c_first_cycle) && cycle_num <= 7'(c_last_cycle)) begin
                ctype = badline ? vic_hgc : vic_hgi;
            end
        end
    end

    // sprite DMA on at cycle 55, off once 21 rows are counted at cycle 15
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dma <= '0;
            for (int n = 0; n < num_sprites; n++) begin
                sprite_row[n] <= '0;
            end
        end else if (lo_dav) begin
            for (int n = 0; n < num_sprites; n++) begin
                if (cycle_num == 7'(dma_check_cycle)) begin
                    if (sprite_en[n] && !dma[n] && sprite_y[n*8 +: 8] == raster[7:0]) begin
                        dma[n]        <= 1'b1;
                        sprite_row[n] <= '0;
                    end
                end else if (cycle_num == 7'(mc_update_cycle) && dma[n]) begin
                    if (sprite_row[n] == 5'(sprite_rows - 1)) begin
                        dma[n] <= 1'b0;
                    end else begin
                        sprite_row[n] <= sprite_row[n] + 5'd1;
                    end
                end
            end
        end
    end

    assign f.cycle_type          = ctype;
    assign f.phi_phase_start_dav = dav;
    assign f.phase_high          = phase_high;
    assign f.sprite_cnt          = spr_num;
    assign f.sprite_dma          = dma;
    assign f.idle                = (state != st_display);
    assign f.badline             = badline;
    // bus stolen only for badline c-accesses
    assign f.aec                 = !(ctype == vic_hrc || ctype == vic_hgc);

endmodule

// ==== bus_access.sv ====
module bus_access import vic_pkg::*; (
    input  logic        clk_dot4x,
    input  logic        rst,
    vic_fetch_if.fetch  f,
    input  logic [11:0] dbi,
    input  logic        vic_write_db,
    output logic [7:0]  sprite_ptr [num_sprites],
    output logic [7:0]  pixels_read,
    output logic [11:0] char_read,
    output logic [11:0] char_next,
    output logic [23:0] sprite_pixels [num_sprites]
);

    // colour and code of the current character row
    logic [11:0] char_buf [char_buf_len];
    logic [5:0]  char_buf_counter;
    logic [11:0] c_word;
    logic        c_slot;
    logic        rd_strobe;

    // code reads as 0xff unless the bus was really stolen
    assign c_word = {dbi[11:8], f.aec ? 8'hff : dbi[7:0]};

    assign c_slot = (f.cycle_type == vic_hrc) || (f.cycle_type == vic_hgc) ||
                    (f.cycle_type == vic_hrx) || (f.cycle_type == vic_hgi);

    assign rd_strobe = !vic_write_db && f.phi_phase_start_dav;

    // c-access and line buffer
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            char_buf_counter <= '0;
            char_next        <= '0;
            for (int n = 0; n < char_buf_len; n++) begin
                char_buf[n] <= 12'h0ff;
            end
        end else if (f.phi_phase_start_dav) begin
            case (f.cycle_type)
                vic_hrc, vic_hgc: begin
                    char_next                  <= c_word;
                    char_buf[char_buf_counter] <= c_word;
                end
                // non-badline, replay the stored row
                vic_hrx, vic_hgi: begin
                    char_next <= char_buf[char_buf_counter];
                end
                default: ;
            endcase
            // 40 c-slots per line, so the counter is back at 0 for cycle 15
            if (c_slot) begin
                if (char_buf_counter == 6'(char_buf_len - 1)) begin
                    char_buf_counter <= '0;
                end else begin
                    char_buf_counter <= char_buf_counter + 6'd1;
                end
            end
        end
    end

    // g-access
    // pixel byte only lasts one phase
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixels_read <= '0;
            char_read   <= '0;
        end else if (rd_strobe) begin
            pixels_read <= '0;
            if (f.cycle_type == vic_lg) begin
                pixels_read <= dbi[7:0];
                char_read   <= f.idle ? 12'd0 : char_next;
            end
        end
    end

    // p-access
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int n = 0; n < num_sprites; n++) begin
                sprite_ptr[n] <= '0;
            end
        end else if (rd_strobe && f.cycle_type == vic_lp) begin
            if (f.sprite_dma[f.sprite_cnt]) begin
                sprite_ptr[f.sprite_cnt] <= dbi[7:0];
            end else begin
                sprite_ptr[f.sprite_cnt] <= 8'hff;
            end
        end
    end

    // s-access
    // three bytes per line shift in msb first
    always_ff @(posedge clk_dot4x) begin
        if (rd_strobe) begin
            case (f.cycle_type)
                vic_hs1, vic_ls2, vic_hs3: begin
                    if (f.sprite_dma[f.sprite_cnt]) begin
                        sprite_pixels[f.sprite_cnt] <=
                            {sprite_pixels[f.sprite_cnt][15:0], dbi[7:0]};
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== vic_addr_gen.sv ====
module vic_addr_gen import vic_pkg::*; #(
    parameter int cycles_per_line = 63
) (
    input  logic        clk_dot4x,
    input  logic        rst,
    vic_fetch_if.addr   f,
    input  logic [8:0]  raster,
    input  logic [6:0]  cycle_num,
    input  logic [11:0] char_next,
    input  logic [7:0]  sprite_ptr [num_sprites],
    input  logic [3:0]  vm_base,
    input  logic [2:0]  cb_base,
    output logic [13:0] vic_addr
);

    logic [9:0] vc_base;
    logic [9:0] vc;
    logic [2:0] rc;
    // sprite data counters, step by 3 once per line
    logic [5:0] mc [num_sprites];
    logic       lo_dav;
    logic       frame_end;
    logic [5:0] s_offset;

    assign lo_dav    = f.phi_phase_start_dav && !f.phase_high;
    assign frame_end = (cycle_num == 7'(cycles_per_line)) &&
                       (raster == 9'(raster_lines - 1));

    // video and row counters
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            vc_base <= '0;
            vc      <= '0;
            rc      <= '0;
        end else if (lo_dav) begin
            if (cycle_num == 7'(vc_load_cycle)) begin
                vc <= vc_base;
                if (f.badline) begin
                    rc <= '0;
                end
            end
            // next c-slot addresses the following column
            if (f.cycle_type == vic_lg && !f.idle) begin
                vc <= vc + 10'd1;
            end
            if (cycle_num == 7'(row_check_cycle)) begin
                if (rc == 3'd7) begin
                    vc_base <= vc;
                end
                if (!f.idle) begin
                    rc <= rc + 3'd1;
                end
            end
            if (frame_end) begin
                vc_base <= '0;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int n = 0; n < num_sprites; n++) begin
                mc[n] <= '0;
            end
        end else begin
            for (int n = 0; n < num_sprites; n++) begin
                if (!f.sprite_dma[n]) begin
                    mc[n] <= '0;
                end else if (lo_dav && cycle_num == 7'(mc_update_cycle)) begin
                    mc[n] <= mc[n] + 6'd3;
                end
            end
        end
    end

    // byte within the current sprite row
    always_comb begin
        case (f.cycle_type)
            vic_ls2: s_offset = 6'd1;
            vic_hs3: s_offset = 6'd2;
            default: s_offset = 6'd0;
        endcase
    end

    always_comb begin
        vic_addr = idle_addr;
        case (f.cycle_type)
            vic_hrc, vic_hgc: vic_addr = {vm_base, vc};
            vic_lg: begin
                if (!f.idle) begin
                    vic_addr = {cb_base, char_next[7:0], rc};
                end
            end
            // pointers sit at the top 8 bytes of the video matrix
            vic_lp: vic_addr = {vm_base, 7'h7f, f.sprite_cnt};
            vic_hs1, vic_ls2, vic_hs3: begin
                vic_addr = {sprite_ptr[f.sprite_cnt], 6'(mc[f.sprite_cnt] + s_offset)};
            end
            default: ;
        endcase
    end

endmodule

// ==== vic_fetch_top.sv ====
module vic_fetch_top import vic_pkg::*; #(
    parameter int cycles_per_line = 63
) (
    input  logic                      clk_dot4x,
    input  logic                      rst,
    input  logic                      den,
    input  logic [2:0]                yscroll,
    input  logic [num_sprites-1:0]    sprite_en,
    input  logic [8*num_sprites-1:0]  sprite_y,
    input  logic [3:0]                vm_base,
    input  logic [2:0]                cb_base,
    input  logic [11:0]               dbi,
    input  logic                      vic_write_db,
    output logic [13:0]               vic_addr,
    output logic                      aec,
    output logic [8:0]                raster,
    output logic [7:0]                pixels_read,
    output logic [11:0]               char_read,
    output logic [8*num_sprites-1:0]  sprite_ptr,
    output logic [24*num_sprites-1:0] sprite_pixels
);

    vic_fetch_if fetch_bus ();

    logic [6:0]  cycle_num;
    logic [11:0] char_next;
    logic [7:0]  sprite_ptr_arr [num_sprites];
    logic [23:0] sprite_pixels_arr [num_sprites];

    vic_cycle_seq #(.cycles_per_line(cycles_per_line)) u_seq (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .den       (den),
        .yscroll   (yscroll),
        .sprite_en (sprite_en),
        .sprite_y  (sprite_y),
        .raster    (raster),
        .cycle_num (cycle_num),
        .f         (fetch_bus.seq)
    );

    bus_access u_bus (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .f             (fetch_bus.fetch),
        .dbi           (dbi),
        .vic_write_db  (vic_write_db),
        .sprite_ptr    (sprite_ptr_arr),
        .pixels_read   (pixels_read),
        .char_read     (char_read),
        .char_next     (char_next),
        .sprite_pixels (sprite_pixels_arr)
    );

    vic_addr_gen #(.cycles_per_line(cycles_per_line)) u_addr (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .f          (fetch_bus.addr),
        .raster     (raster),
        .cycle_num  (cycle_num),
        .char_next  (char_next),
        .sprite_ptr (sprite_ptr_arr),
        .vm_base    (vm_base),
        .cb_base    (cb_base),
        .vic_addr   (vic_addr)
    );

    assign aec = fetch_bus.aec;

    // sprite 0 in the low bits
    for (genvar n = 0; n < num_sprites; n++) begin : g_flat
        assign sprite_ptr[n*8 +: 8]     = sprite_ptr_arr[n];
        assign sprite_pixels[n*24 +: 24] = sprite_pixels_arr[n];
    end

endmodule

// ==== tb_fetch_model.svh ====
`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

// expected fetch counters and latched values
logic [9:0]             m_vc;
logic [9:0]             m_vc_base;
logic [2:0]             m_rc;
logic                   m_display;
logic [5:0]             m_mc [num_sprites];
int                     m_row [num_sprites];
logic [num_sprites-1:0] m_dma;
logic [7:0]             m_ptr [num_sprites];
logic [11:0]            m_char_buf [char_buf_len];
logic [11:0]            m_char_next;
logic [11:0]            m_char_read;
logic [7:0]             m_pixels;

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic is_badline(input int r);
    return (r >= badline_first) && (r <= badline_last) && (3'(r) == yscroll);
endfunction

// two cycles per sprite with sprites 3..7 at cycles 1..10 and 0..2 at 58..63
function automatic int sprite_for_cycle(input int c);
    if (c >= 1 && c <= 10) begin
        return (c - 1) / 2 + 3;
    end else if (c >= 58 && c <= 63) begin
        return (c - 58) / 2;
    end
    return 0;
endfunction

function automatic cycle_t slot_type(input int c, input logic hi, input logic bad);
    int k;
    if ((c >= 1 && c <= 10) || (c >= 58 && c <= 63)) begin
        k = (c >= 58) ? c - 58 : c - 1;
        if (k % 2 == 0) begin
            return hi ? vic_hs1 : vic_lp;
        end
        return hi ? vic_hs3 : vic_ls2;
    end
    if (!hi) begin
        if (c >= 11 && c <= 15) begin
            return vic_lr;
        end
        return (c >= 16 && c <= 55) ? vic_lg : vic_li;
    end
    if (c == 15) begin
        return bad ? vic_hrc : vic_hrx;
    end
    if (c >= 16 && c <= 54) begin
        return bad ? vic_hgc : vic_hgi;
    end
    return vic_hi;
endfunction

function automatic logic [13:0] expected_addr(input cycle_t ct, input int n);
    case (ct)
        vic_hrc, vic_hgc: return 14'(vm_base) * 14'd1024 + 14'(m_vc);
        vic_lg: begin
            if (m_display) begin
                return 14'(cb_base) * 14'd2048 + 14'(m_char_next[7:0]) * 14'd8 + 14'(m_rc);
            end
            return 14'h3fff;
        end
        vic_lp:           return 14'(vm_base) * 14'd1024 + 14'h3f8 + 14'(n);
        vic_hs1:          return 14'(m_ptr[n]) * 14'd64 + 14'(m_mc[n]);
        vic_ls2:          return 14'(m_ptr[n]) * 14'd64 + 14'(m_mc[n]) + 14'd1;
        vic_hs3:          return 14'(m_ptr[n]) * 14'd64 + 14'(m_mc[n]) + 14'd2;
        default:          return 14'h3fff;
    endcase
endfunction

// three sprite bytes with the first fetched in the top bits
function automatic logic [23:0] dma_bytes(input int n);
    int base;
    base = int'(m_ptr[n]) * 64 + int'(m_mc[n]);
    return {mem[base][7:0], mem[base + 1][7:0], mem[base + 2][7:0]};
endfunction

function automatic void low_phase_update(input cycle_t ct, input int c, input int n,
                                         input logic [11:0] w, input logic bad);
    logic [9:0] vc_next;
    logic [2:0] rc_next;
    vc_next = m_vc;
    rc_next = m_rc;
    if (c == 14) begin
        vc_next = m_vc_base;
        if (bad) begin
            rc_next = 3'd0;
        end
    end
    if (ct == vic_lg && m_display) begin
        vc_next = m_vc + 10'd1;
    end
    if (c == 58) begin
        if (m_rc == 3'd7) begin
            m_vc_base = m_vc;
        end
        if (m_display) begin
            rc_next = m_rc + 3'd1;
        end
    end
    if (c == cpl && m_raster == raster_lines - 1) begin
        m_vc_base = 10'd0;
    end
    m_vc = vc_next;
    m_rc = rc_next;
    m_pixels = (ct == vic_lg) ? w[7:0] : 8'h00;
    if (ct == vic_lg) begin
        m_char_read = m_display ? m_char_next : 12'h000;
    end
    if (ct == vic_lp) begin
        m_ptr[n] = m_dma[n] ? w[7:0] : 8'hff;
    end
    for (int s = 0; s < num_sprites; s++) begin
        if (c == 55 && sprite_en[s] && !m_dma[s] && sprite_y[s*8 +: 8] == 8'(m_raster)) begin
            m_dma[s] = 1'b1;
            m_row[s] = 0;
        end else if (c == 15 && m_dma[s]) begin
            m_mc[s] = m_mc[s] + 6'd3;
            if (m_row[s] == sprite_rows - 1) begin
                m_dma[s] = 1'b0;
                m_mc[s]  = 6'd0;
            end else begin
                m_row[s]++;
            end
        end
    end
endfunction

// badline c-slots fill the row buffer and other lines replay it
function automatic void c_slot_update(input cycle_t ct, input int c, input logic [11:0] w);
    m_pixels = 8'h00;
    if (ct == vic_hrc || ct == vic_hgc) begin
        m_char_buf[c - 15] = w;
        m_char_next = w;
    end else if (ct == vic_hrx || ct == vic_hgi) begin
        m_char_next = m_char_buf[c - 15];
    end
endfunction

`endif

// ==== tb_vic_fetch.sv ====
module tb_vic_fetch import vic_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int cpl         = 63;
    // one frame plus the extra cycle 0 after reset
    localparam int frame_ticks = ticks_per_cycle * (1 + raster_lines * cpl);
    localparam int tick_limit  = 16 + frame_ticks + frame_ticks / 10;

    logic         clk_dot4x;
    logic         rst;
    logic         den;
    logic [2:0]   yscroll;
    logic [7:0]   sprite_en;
    logic [63:0]  sprite_y;
    logic [3:0]   vm_base;
    logic [2:0]   cb_base;
    logic [11:0]  dbi;
    logic         vic_write_db;
    logic [13:0]  vic_addr;
    logic         aec;
    logic [8:0]   raster;
    logic [7:0]   pixels_read;
    logic [11:0]  char_read;
    logic [63:0]  sprite_ptr;
    logic [191:0] sprite_pixels;

    logic [11:0]  mem [16384];
    logic [31:0]  rng;
    int           m_tick;
    int           m_cycle;
    int           m_raster;
    int           checks [6];
    int           errors [6];
    int           cycle_count = 0;
    string        test_name [6] = '{"address sequence", "badline fetch", "cached characters",
                                    "idle lines", "sprite pointers", "sprite data"};

    `include "tb_fetch_model.svh"

    always #2 clk_dot4x = ~clk_dot4x;

    // video memory answers without wait states
    assign dbi = mem[vic_addr];

    vic_fetch_top #(.cycles_per_line(cpl)) DUT (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .den           (den),
        .yscroll       (yscroll),
        .sprite_en     (sprite_en),
        .sprite_y      (sprite_y),
        .vm_base       (vm_base),
        .cb_base       (cb_base),
        .dbi           (dbi),
        .vic_write_db  (vic_write_db),
        .vic_addr      (vic_addr),
        .aec           (aec),
        .raster        (raster),
        .pixels_read   (pixels_read),
        .char_read     (char_read),
        .sprite_ptr    (sprite_ptr),
        .sprite_pixels (sprite_pixels)
    );

    always @(posedge clk_dot4x) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= tick_limit) begin
            $display("timeout: run still going after %0d clock cycles", cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic compare_value(input int t, input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks[t]++;
        assert (got === exp) else begin
            errors[t]++;
            $display("mismatch %s: got 0x%h expected 0x%h (raster %0d cycle %0d)",
                     name, got, exp, m_raster, m_cycle);
        end
    endtask

    // sampled one tick after the data strobe while slot and address hold
    task automatic sample_phase();
        cycle_t      ct;
        logic [13:0] addr;
        logic [11:0] word;
        logic        hi;
        logic        bad;
        logic        steal;
        int          n;
        int          t;
        hi    = (m_tick >= ticks_per_cycle / 2);
        bad   = is_badline(m_raster);
        ct    = slot_type(m_cycle, hi, bad);
        n     = sprite_for_cycle(m_cycle);
        addr  = expected_addr(ct, n);
        word  = mem[addr];
        // bus taken in the high phase of the 40 c-slot cycles of a badline
        steal = hi && bad && m_cycle >= 15 && m_cycle <= 54;
        compare_value(0, "vic_addr", vic_addr, addr);
        compare_value(0, "aec", aec, steal ? 0 : 1);
        compare_value(0, "raster", raster, m_raster);
        if (hi) begin
            c_slot_update(ct, m_cycle, word);
        end else begin
            low_phase_update(ct, m_cycle, n, word, bad);
        end
        if (ct == vic_lg) begin
            t = bad ? 1 : (m_display ? 2 : 3);
            if (t == 3) begin
                compare_value(3, "vic_addr", vic_addr, 14'h3fff);
                compare_value(3, "char_read", char_read, 0);
            end else begin
                compare_value(t, "char_read", char_read, m_char_read);
            end
            compare_value(t, "pixels_read", pixels_read, m_pixels);
        end else begin
            compare_value(0, "pixels_read", pixels_read, 0);
        end
        if (ct == vic_lp) begin
            compare_value(4, "sprite_ptr", sprite_ptr[n*8 +: 8], m_ptr[n]);
        end
        if (ct == vic_hs3 && m_dma[n]) begin
            compare_value(5, "sprite_pixels", sprite_pixels[n*24 +: 24], dma_bytes(n));
        end
    endtask

    initial begin
        int total_checks;
        int total_errors;
        clk_dot4x    = 1'b0;
        rst          = 1'b1;
        den          = 1'b1;
        vic_write_db = 1'b0;
        rng          = 32'd20;
        for (int i = 0; i < 16384; i++) begin
            rng    = xorshift(rng);
            mem[i] = rng[11:0];
        end
        rng       = xorshift(rng);
        yscroll   = rng[2:0];
        vm_base   = rng[6:3];
        cb_base   = rng[9:7];
        sprite_en = rng[17:10];
        // at least one sprite so the DMA paths get exercised
        if (sprite_en == 8'h00) begin
            sprite_en = 8'h81;
        end
        rng = xorshift(rng);
        sprite_y[31:0] = rng;
        rng = xorshift(rng);
        sprite_y[63:32] = rng;
        $display("run: yscroll %0d vm_base 0x%h cb_base 0x%h sprite_en 0x%h",
                 yscroll, vm_base, cb_base, sprite_en);

        m_vc = '0;
        m_vc_base = '0;
        m_rc = '0;
        m_display = 1'b0;
        m_dma = '0;
        m_char_next = '0;
        m_char_read = '0;
        m_pixels = '0;
        for (int s = 0; s < num_sprites; s++) begin
            m_mc[s]  = '0;
            m_row[s] = 0;
            m_ptr[s] = '0;
        end
        for (int i = 0; i < char_buf_len; i++) begin
            m_char_buf[i] = 12'h0ff;
        end
        m_tick = 0;
        m_cycle = 0;
        m_raster = 0;

        repeat (16) @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        rst = 1'b0;

        repeat (frame_ticks) begin
            if (m_tick == dav_tick_low + 1 || m_tick == dav_tick_high + 1) begin
                sample_phase();
            end
            if (m_tick == ticks_per_cycle - 1) begin
                m_tick = 0;
                if (m_cycle == cpl) begin
                    m_cycle = 1;
                    m_raster = (m_raster + 1) % raster_lines;
                    // display starts on a badline and ends with the window
                    if (m_raster < badline_first || m_raster > badline_last) begin
                        m_display = 1'b0;
                    end else if (is_badline(m_raster)) begin
                        m_display = 1'b1;
                    end
                end else begin
                    m_cycle++;
                end
            end else begin
                m_tick++;
            end
            @(negedge clk_dot4x);
        end

        total_checks = 0;
        total_errors = 0;
        for (int t = 0; t < 6; t++) begin
            if (checks[t] == 0) begin
                errors[t]++;
                $display("test %0d %s: no checks ran", t + 1, test_name[t]);
            end else begin
                $display("test %0d %s: %0d checks, %0d errors",
                         t + 1, test_name[t], checks[t], errors[t]);
            end
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+.
vic_pkg.sv
vic_fetch_if.sv
vic_cycle_seq.sv
bus_access.sv
vic_addr_gen.sv
vic_fetch_top.sv
tb_vic_fetch.sv
